// File: hdl/i2c_pkg.sv
// shared widths, timing constants and the sequencer state encoding
// for the I2C sensor readout; modules pull this in with a wildcard import
package i2c_pkg;

	localparam int STEP_DIVIDE = 4; // clocks per sequencer step
	localparam int POLL_INTERVAL = 64; // idle clocks between transfers
	localparam int DATA_BYTES = 4; // bytes read back per transfer

	typedef logic [6:0] i2c_address_t;
	typedef logic [7:0] i2c_byte_t;
	typedef logic [8:0] i2c_step_t;
	typedef logic [31:0] sample_t; // byte_a in the top byte
	typedef logic [7:0] error_count_t;
	typedef logic [$clog2(STEP_DIVIDE)-1:0] step_phase_t;
	typedef logic [$clog2(POLL_INTERVAL)-1:0] poll_count_t;

	// step table, counted down from FIRST_STEP to 1
	localparam i2c_step_t FIRST_STEP = 9'd300;
	localparam i2c_step_t ABORT_STEP = 9'd10; // lands just before the final stop
	localparam i2c_step_t WR_ADDR_STEP = 9'd278; // first step of address + write bit
	localparam i2c_step_t RD_ADDR_STEP = 9'd219; // first step of address + read bit
	localparam i2c_step_t ADDR_STEPS = 9'd24; // 8 bits, 3 steps each
	localparam i2c_step_t DATA_STEP = 9'd169; // first step of the first data byte
	localparam i2c_step_t BYTE_STEPS = 9'd40; // spacing of data byte windows

	localparam step_phase_t STEP_LAST = step_phase_t'(STEP_DIVIDE - 1);
	localparam poll_count_t POLL_LAST = poll_count_t'(POLL_INTERVAL - 1);

	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} sequencer_state_t;

endpackage

// File: hdl/i2c_step_timer.sv
// free-running divider for the I2C sequencer
// step_tick is high for one clock out of every STEP_DIVIDE, which sets
// the length of one table step and so the SCL rate
`timescale 1ns/100ps

module i2c_step_timer import i2c_pkg::*; (
	input  logic clock,
	input  logic rst,
	output logic step_tick
);

	step_phase_t count;

	always_ff @(posedge clock) begin
		if (rst) begin
			count <= '0;
			step_tick <= 1'b0;
		end else begin
			step_tick <= (count == STEP_LAST); // one pulse per wrap
			if (count == STEP_LAST) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: hdl/i2c_transfer_sequencer.sv
// step-table I2C master for one fixed sensor transaction
// write address + ACK check, stop, read address + ACK check, four bytes
// (ACK, ACK, ACK, NACK) and a final stop; start_transfer is taken in idle only
// and busy stays high until the step count is back at zero
`timescale 1ns/100ps

module i2c_transfer_sequencer import i2c_pkg::*; (
	input  logic         clock,
	input  logic         rst,
	input  logic         step_tick,
	input  logic         start_transfer,
	input  i2c_address_t address,
	input  logic         sda_in,
	output logic         scl,
	output logic         sda_out,
	output logic         sda_dir,
	output logic         busy,
	output logic         nack,
	output i2c_byte_t    byte_a,
	output i2c_byte_t    byte_b,
	output i2c_byte_t    byte_c,
	output i2c_byte_t    byte_d
);

	sequencer_state_t state;
	i2c_step_t step; // counts down, 0 when idle
	i2c_byte_t shift_byte; // address out, data in

	logic tick_run;
	logic in_addr;
	logic in_data;
	logic data_bits;
	logic [1:0] phase;
	logic [1:0] byte_sel;
	i2c_step_t addr_off;
	i2c_step_t data_off;
	i2c_step_t data_slot;

	// bit-level strobes decoded from the step number
	logic drive_bit;
	logic scl_rise;
	logic scl_fall;
	logic sample_bit;
	logic byte_done;

	assign busy = (state == SEQ_RUN);
	assign tick_run = step_tick && (state == SEQ_RUN);

	// address and data bits repeat every 3 steps
	// and are decoded by their offset into the window
	always_comb begin
		in_addr = 1'b0;
		in_data = 1'b0;
		addr_off = '0;
		data_off = '0;
		byte_sel = '0;
		data_slot = DATA_STEP - step;
		if (step <= WR_ADDR_STEP && step > WR_ADDR_STEP - ADDR_STEPS) begin
			in_addr = 1'b1;
			addr_off = WR_ADDR_STEP - step;
		end else if (step <= RD_ADDR_STEP && step > RD_ADDR_STEP - ADDR_STEPS) begin
			in_addr = 1'b1;
			addr_off = RD_ADDR_STEP - step;
		end else if (step <= DATA_STEP && data_slot < DATA_BYTES * BYTE_STEPS) begin
			in_data = 1'b1;
			byte_sel = 2'(data_slot / BYTE_STEPS);
			data_off = data_slot % BYTE_STEPS;
		end
		phase = in_addr ? 2'(addr_off % 3) : 2'(data_off % 3);
		data_bits = in_data && data_off != '0 && data_off <= 24; // 8 bits x 3 steps

		drive_bit = in_addr && phase == 2'd0;
		scl_rise = (in_addr && phase == 2'd1) || (data_bits && phase == 2'd1)
			|| (in_data && data_off == 9'd32);
		scl_fall = (in_addr && phase == 2'd2) || (data_bits && phase == 2'd0)
			|| (in_data && data_off == 9'd33);
		sample_bit = data_bits && phase == 2'd2; // scl is high here
		byte_done = in_data && data_off == 9'd25;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= SEQ_IDLE;
			step <= '0;
			scl <= 1'b1; // idle bus, master driving high
			sda_out <= 1'b1;
			sda_dir <= 1'b1;
			nack <= 1'b0;
		end else if (state == SEQ_IDLE) begin
			if (start_transfer) begin
				state <= SEQ_RUN;
				step <= FIRST_STEP;
				nack <= 1'b0;
			end
		end else if (step_tick) begin
			step <= step - 1'b1;
			if (step == 9'd1) begin
				state <= SEQ_IDLE;
			end
			if (drive_bit) sda_out <= shift_byte[7]; // msb first
			if (scl_rise) scl <= 1'b1;
			if (scl_fall) scl <= 1'b0;
			if (in_data) begin
				case (data_off)
					9'd0: sda_dir <= 1'b0; // target drives the byte
					9'd30: sda_dir <= 1'b1;
					9'd31: sda_out <= (byte_sel == 2'd3); // NACK only the last byte
					default: ;
				endcase
			end
			case (step)
				9'd300: begin
					sda_dir <= 1'b1;
					scl <= 1'b1;
					sda_out <= 1'b1;
				end

				// start, then address with write bit
				9'd289: sda_out <= 1'b1;
				9'd288: scl <= 1'b1;
				9'd287: sda_out <= 1'b0; // start condition
				9'd286: scl <= 1'b0;

				// ACK for the write address
				9'd249: sda_dir <= 1'b0;
				9'd248: scl <= 1'b1;
				9'd247: nack <= sda_in;
				9'd246: scl <= 1'b0;
				9'd245: sda_dir <= 1'b1;
				9'd244: if (nack) step <= ABORT_STEP;

				// stop
				9'd240: sda_out <= 1'b1;
				9'd239: sda_out <= 1'b0;
				9'd238: scl <= 1'b1;
				9'd237: sda_out <= 1'b1; // stop condition

				// repeated start, then address with read bit
				9'd229: sda_out <= 1'b1;
				9'd228: scl <= 1'b1;
				9'd227: sda_out <= 1'b0;
				9'd226: scl <= 1'b0;

				// ACK for the read address; SDA stays released for the data
				9'd189: sda_dir <= 1'b0;
				9'd188: scl <= 1'b1;
				9'd187: nack <= sda_in;
				9'd186: scl <= 1'b0;
				9'd184: if (nack) step <= ABORT_STEP;

				// final stop and abort target
				9'd9: sda_dir <= 1'b1;
				9'd8: sda_out <= 1'b1;
				9'd7: sda_out <= 1'b0;
				9'd6: scl <= 1'b1;
				9'd5: sda_out <= 1'b1;

				9'd1: begin
					sda_dir <= 1'b1;
					scl <= 1'b1;
					sda_out <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// byte shifter and held data bytes
	always_ff @(posedge clock) begin
		if (tick_run) begin
			if (step == 9'd286) begin
				shift_byte <= {address, 1'b0}; // write
			end else if (step == 9'd226) begin
				shift_byte <= {address, 1'b1}; // read
			end else if (drive_bit) begin
				shift_byte <= {shift_byte[6:0], 1'b0};
			end else if (sample_bit) begin
				shift_byte <= {shift_byte[6:0], sda_in};
			end
			if (byte_done) begin
				case (byte_sel)
					2'd0: byte_a <= shift_byte;
					2'd1: byte_b <= shift_byte;
					2'd2: byte_c <= shift_byte;
					2'd3: byte_d <= shift_byte;
				endcase
			end
		end
	end

	a_busy_step: assert property (@(posedge clock) disable iff (rst)
		busy |-> step != '0);

	// data may only move while the clock holds still, else a false start/stop
	a_scl_sda: assert property (@(posedge clock) disable iff (rst)
		(!$past(rst) && $changed(scl)) |-> $stable(sda_out));

endmodule

// File: hdl/measurement_poller.sv
// periodic transfer scheduler for the sensor readout
// fires start_transfer after POLL_INTERVAL idle clocks, then on the end of
// each transfer either packs the four bytes into sample or counts a NACK
`timescale 1ns/100ps

module measurement_poller import i2c_pkg::*; (
	input  logic         clock,
	input  logic         rst,
	input  logic         poll_enable,
	input  logic         busy,
	input  logic         nack,
	input  i2c_byte_t    byte_a,
	input  i2c_byte_t    byte_b,
	input  i2c_byte_t    byte_c,
	input  i2c_byte_t    byte_d,
	output logic         start_transfer,
	output sample_t      sample,
	output logic         sample_valid,
	output error_count_t nack_count
);

	poll_count_t interval_count;
	logic busy_d;
	logic busy_fall;

	assign busy_fall = busy_d && !busy; // transfer just ended

	always_ff @(posedge clock) begin
		if (rst) begin
			interval_count <= '0;
			start_transfer <= 1'b0;
			busy_d <= 1'b0;
			sample_valid <= 1'b0;
			nack_count <= '0;
		end else begin
			busy_d <= busy;
			start_transfer <= 1'b0;
			sample_valid <= 1'b0;

			// hold off while a start is in flight, busy rises a clock later
			if (busy || !poll_enable || start_transfer) begin
				interval_count <= '0;
			end else if (interval_count == POLL_LAST) begin
				interval_count <= '0;
				start_transfer <= 1'b1;
			end else begin
				interval_count <= interval_count + 1'b1;
			end

			if (busy_fall) begin
				if (!nack) begin
					sample_valid <= 1'b1;
				end else if (nack_count != '1) begin
					nack_count <= nack_count + 1'b1; // saturates
				end
			end
		end
	end

	// sample only changes on a good transfer, previous one is overwritten
	always_ff @(posedge clock) begin
		if (busy_fall && !nack) begin
			sample <= {byte_a, byte_b, byte_c, byte_d};
		end
	end

	a_no_start_busy: assert property (@(posedge clock) disable iff (rst)
		!(start_transfer && busy));

endmodule

// File: hdl/sensor_readout_top.sv
// top level of the I2C sensor readout
// step timer paces the transfer sequencer, the poller schedules transfers
// and collects samples; SDA is split into sda_out/sda_dir/sda_in and the
// open-drain line is resolved outside
`timescale 1ns/100ps

module sensor_readout_top import i2c_pkg::*; (
	input  logic         clock,
	input  logic         rst,
	input  logic         poll_enable,
	input  i2c_address_t target_address,
	input  logic         sda_in,
	output logic         scl,
	output logic         sda_out,
	output logic         sda_dir,
	output sample_t      sample,
	output logic         sample_valid,
	output error_count_t nack_count
);

	logic step_tick;
	logic start_transfer;
	logic busy;
	logic nack;
	i2c_byte_t byte_a;
	i2c_byte_t byte_b;
	i2c_byte_t byte_c;
	i2c_byte_t byte_d;

	i2c_step_timer i2c_step_timer_inst (
		.clock     (clock),
		.rst       (rst),
		.step_tick (step_tick)
	);

	i2c_transfer_sequencer i2c_transfer_sequencer_inst (
		.clock          (clock),
		.rst            (rst),
		.step_tick      (step_tick),
		.start_transfer (start_transfer),
		.address        (target_address),
		.sda_in         (sda_in),
		.scl            (scl),
		.sda_out        (sda_out),
		.sda_dir        (sda_dir),
		.busy           (busy),
		.nack           (nack),
		.byte_a         (byte_a),
		.byte_b         (byte_b),
		.byte_c         (byte_c),
		.byte_d         (byte_d)
	);

	measurement_poller measurement_poller_inst (
		.clock          (clock),
		.rst            (rst),
		.poll_enable    (poll_enable),
		.busy           (busy),
		.nack           (nack),
		.byte_a         (byte_a),
		.byte_b         (byte_b),
		.byte_c         (byte_c),
		.byte_d         (byte_d),
		.start_transfer (start_transfer),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.nack_count     (nack_count)
	);

endmodule

// File: verification/i2c_target_model.sv
// behavioral I2C target for the sensor readout testbench
// watches SCL and the resolved SDA line once per clock, ACKs device_address
// and returns the four bytes of pattern, top byte and msb first
`timescale 1ns/100ps

module i2c_target_model import i2c_pkg::*; (
	input  logic         clock,
	input  logic         rst,
	input  logic         scl,
	input  logic         sda,
	input  i2c_address_t device_address,
	input  sample_t      pattern,
	output logic         sda_release
);

	typedef enum {T_IDLE, T_ADDR, T_ACK, T_READ} target_state_t;

	target_state_t state;
	i2c_byte_t shift_byte; // address + r/w bit
	int bit_count;
	int byte_index;
	logic master_nack;
	logic scl_prev;
	logic sda_prev;

	function automatic logic pattern_bit(input int byte_sel, input int bit_sel);
		return pattern[31 - 8 * byte_sel - bit_sel];
	endfunction

	initial begin
		state = T_IDLE;
		sda_release = 1'b1;
		shift_byte = '0;
		bit_count = 0;
		byte_index = 0;
		master_nack = 1'b0;
		scl_prev = 1'b1;
		sda_prev = 1'b1;
		forever begin
			@(posedge clock);
			#1;
			if (rst) begin
				state = T_IDLE;
				sda_release = 1'b1;
			end else if (scl && scl_prev && sda_prev && !sda) begin
				state = T_ADDR; // start or repeated start
				bit_count = 0;
				sda_release = 1'b1;
			end else if (scl && scl_prev && !sda_prev && sda) begin
				state = T_IDLE; // stop
				sda_release = 1'b1;
			end else if (scl && !scl_prev) begin
				if (state == T_ADDR) begin
					shift_byte = {shift_byte[6:0], sda};
					bit_count++;
				end else if (state == T_READ) begin
					if (bit_count == 8)
						master_nack = sda; // master ACK clock
					bit_count++;
				end
			end else if (!scl && scl_prev) begin
				case (state)
					T_ADDR: begin
						if (bit_count == 8 && shift_byte[7:1] == device_address) begin
							sda_release = 1'b0; // address ACK
							state = T_ACK;
						end else if (bit_count == 8) begin
							state = T_IDLE; // someone else's address
						end
					end
					T_ACK: begin
						if (shift_byte[0]) begin
							state = T_READ;
							byte_index = 0;
							bit_count = 0;
							sda_release = pattern_bit(0, 0);
						end else begin
							state = T_IDLE;
							sda_release = 1'b1;
						end
					end
					T_READ: begin
						if (bit_count < 8) begin
							sda_release = pattern_bit(byte_index, bit_count);
						end else if (bit_count == 8) begin
							sda_release = 1'b1; // let the master ACK
						end else if (master_nack || byte_index == 3) begin
							state = T_IDLE;
							sda_release = 1'b1;
						end else begin
							byte_index++;
							bit_count = 0;
							sda_release = pattern_bit(byte_index, 0);
						end
					end
					default: ;
				endcase
			end
			scl_prev = scl;
			sda_prev = sda;
		end
	end

endmodule

// File: verification/sensor_readout_tb.sv
// directed testbench for the I2C sensor readout
// resolves SDA as a wired-AND of the DUT and a target model, then runs
// polling, NACK, enable and reset tests against the model's pattern
`timescale 1ns/100ps

module sensor_readout_tb import i2c_pkg::*; ();

	localparam int TRANSFER_CLOCKS = POLL_INTERVAL + int'(FIRST_STEP) * STEP_DIVIDE;
	localparam int MIN_TRANSFER = POLL_INTERVAL + (int'(FIRST_STEP) - 1) * STEP_DIVIDE;
	localparam int TEST_COUNT = 5;
	localparam int CYCLE_LIMIT = TEST_COUNT * TRANSFER_CLOCKS * 3;

	logic clock;
	logic rst;
	logic poll_enable;
	i2c_address_t target_address;
	logic sda_in;
	logic scl;
	logic sda_out;
	logic sda_dir;
	sample_t sample;
	logic sample_valid;
	error_count_t nack_count;
	logic target_release;
	i2c_address_t device_address;
	sample_t pattern;
	int errors;
	int cycles = 0;

	assign sda_in = (sda_dir ? sda_out : 1'b1) & target_release; // open-drain bus

	sensor_readout_top sensor_readout_top_inst (
		.clock          (clock),
		.rst            (rst),
		.poll_enable    (poll_enable),
		.target_address (target_address),
		.sda_in         (sda_in),
		.scl            (scl),
		.sda_out        (sda_out),
		.sda_dir        (sda_dir),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.nack_count     (nack_count)
	);

	i2c_target_model target_model_inst (
		.clock          (clock),
		.rst            (rst),
		.scl            (scl),
		.sda            (sda_in),
		.device_address (device_address),
		.pattern        (pattern),
		.sda_release    (target_release)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#1; // outputs settled, inputs change here
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) next_cycle();
		rst = 1'b0;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got == expected) else begin
			errors++;
			$display("error: %s is %h, expected %h", name, got, expected);
		end
	endtask

	task automatic require(input logic cond, input string what);
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic verify_idle_bus();
		compare_value("scl", 32'(scl), 32'h1);
		compare_value("sda_out", 32'(sda_out), 32'h1);
		compare_value("sda_dir", 32'(sda_dir), 32'h1);
	endtask

	// always moves at least one clock, so a pulse is never seen twice
	task automatic wait_for_sample(input int limit, output int waited);
		waited = 0;
		do begin
			next_cycle();
			waited++;
		end while (!sample_valid && waited < limit);
		require(sample_valid, "sample_valid never pulsed within one transfer time");
	endtask

	task automatic read_matching_target();
		int waited;
		device_address = 7'h48;
		target_address = 7'h48;
		pattern = 32'hA53C_0F96;
		poll_enable = 1'b1;
		apply_reset();
		wait_for_sample(TRANSFER_CLOCKS + 32, waited);
		compare_value("sample", sample, pattern);
		compare_value("nack_count", 32'(nack_count), 32'h0);
	endtask

	task automatic count_wrong_address_nacks();
		int starts;
		int nacks;
		logic start_armed;
		error_count_t last_count;
		device_address = 7'h48;
		target_address = 7'h29;
		pattern = 32'h1234_5678;
		poll_enable = 1'b1;
		apply_reset();
		starts = 0;
		nacks = 0;
		last_count = nack_count;
		repeat (TRANSFER_CLOCKS) begin
			start_armed = scl && sda_out;
			next_cycle();
			if (start_armed && scl && !sda_out && sda_dir)
				starts++; // start condition from the master
			require(!sample_valid, "sample_valid pulsed although the target never ACKed");
			if (nack_count != last_count) begin
				nacks++;
				compare_value("nack_count", 32'(nack_count), 32'(last_count) + 32'd1);
				require(starts == nacks, "nack_count did not step once per attempted transfer");
				verify_idle_bus();
				last_count = nack_count;
			end
		end
		require(nacks >= 2, "too few NACKed transfers within one transfer time");
	endtask

	task automatic poll_three_patterns();
		int waited;
		device_address = 7'h48;
		target_address = 7'h48;
		poll_enable = 1'b1;
		pattern = $urandom();
		apply_reset();
		repeat (3) begin
			wait_for_sample(TRANSFER_CLOCKS + 32, waited);
			compare_value("sample", sample, pattern);
			verify_idle_bus();
			pattern = $urandom(); // bus idle until the next poll
		end
	endtask

	task automatic hold_when_disabled();
		int waited;
		device_address = 7'h48;
		target_address = 7'h48;
		pattern = 32'h0FF0_C33C;
		poll_enable = 1'b0;
		apply_reset();
		repeat (2 * POLL_INTERVAL) begin
			next_cycle();
			require(scl, "scl left idle while polling was disabled");
			require(!sample_valid, "sample_valid pulsed while polling was disabled");
		end
		poll_enable = 1'b1;
		wait_for_sample(TRANSFER_CLOCKS + 32, waited);
		compare_value("sample", sample, pattern);
	endtask

	task automatic reset_mid_transfer();
		int waited;
		device_address = 7'h48;
		target_address = 7'h48;
		pattern = 32'hC0DE_5A17;
		poll_enable = 1'b1;
		apply_reset();
		waited = 0;
		while (scl && waited < TRANSFER_CLOCKS) begin
			next_cycle();
			waited++;
		end
		require(!scl, "no transfer started before the mid-transfer reset");
		repeat (TRANSFER_CLOCKS / 2) next_cycle(); // well into the data bytes
		apply_reset();
		verify_idle_bus();
		compare_value("sample_valid", 32'(sample_valid), 32'h0);
		compare_value("nack_count", 32'(nack_count), 32'h0);
		wait_for_sample(TRANSFER_CLOCKS + 32, waited);
		require(waited >= MIN_TRANSFER, "sample_valid came before a full transfer after reset");
		compare_value("sample", sample, pattern);
	endtask

	initial begin
		void'($urandom(10));
		rst = 1'b1;
		poll_enable = 1'b0;
		target_address = 7'h48;
		device_address = 7'h48;
		pattern = '0;
		errors = 0;
		read_matching_target();
		count_wrong_address_nacks();
		poll_three_patterns();
		hold_when_disabled();
		reset_mid_transfer();
		$display("errors: %0d, cycles: %0d", errors, cycles);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sensor_readout_top.f
hdl/i2c_pkg.sv
hdl/i2c_step_timer.sv
hdl/i2c_transfer_sequencer.sv
hdl/measurement_poller.sv
hdl/sensor_readout_top.sv
verification/i2c_target_model.sv
verification/sensor_readout_tb.sv

// File: Makefile
# Verilator build and run for the I2C sensor readout testbench
# usage: make compile | make run | make clean, variables may be overridden

VERILATOR ?= verilator
TOP ?= sensor_readout_tb
FILELIST ?= sensor_readout_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
